// ==== src/noteFixedPkg.sv ====
// note fixed-point format and visualizer FSM states
package noteFixedPkg;

	// ------------------------------------------------------------
	// fixed-point layout, whole part on top
	// ------------------------------------------------------------
	localparam int wholeBits = 6;                   // max whole value 63
	localparam int fracBits  = 10;                  // roughly .001 resolution
	localparam int noteWidth = wholeBits + fracBits;

	// used for positions (LED units) and for amplitudes
	typedef logic [noteWidth-1:0] noteValue;

	// ------------------------------------------------------------
	// visualizer FSM
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		vizIdle,    // waiting for start
		vizBin,     // one bin per cycle
		vizPublish  // copy results out, pulse frameValid
	} vizState;

endpackage

// ==== src/ledStripPkg.sv ====
// WS2801 strip geometry, serial timing, bin palette and driver FSM states
package ledStripPkg;

	// ------------------------------------------------------------
	// strip and bins
	// ------------------------------------------------------------
	localparam int ledCount    = 50;                   // LEDs chained on the strip
	localparam int binQty      = 12;                   // note bins per frame
	localparam int countWidth  = $clog2(ledCount) + 1; // per-bin run, 0..ledCount
	localparam int binIdxWidth = $clog2(binQty);

	// ------------------------------------------------------------
	// serial timing
	// ------------------------------------------------------------
	localparam int freqDiv     = 4;                    // sys clocks per serial bit
	localparam int phaseWidth  = $clog2(freqDiv);
	localparam int latchCycles = 64;                   // clkOut low gap after a frame
	localparam int latchWidth  = $clog2(latchCycles);
	localparam int wordBits    = 24;
	localparam int bitCntWidth = $clog2(wordBits);

	typedef logic [wordBits-1:0] rgbWord;              // {red, green, blue}

	// palette mask bit positions
	localparam int maskRed   = 2;
	localparam int maskGreen = 1;
	localparam int maskBlue  = 0;

	// bin 0 is the rightmost entry: red, yellow, green, cyan, blue, magenta, repeat
	localparam logic [binQty-1:0][2:0] paletteMask = {
		3'b101, 3'b001, 3'b011, 3'b010, 3'b110, 3'b100,
		3'b101, 3'b001, 3'b011, 3'b010, 3'b110, 3'b100
	};

	typedef enum logic [2:0] {
		stripIdle,  // wait for a frame
		stripLoad,  // hand a word to the shifter, or skip an empty bin
		stripShift, // word on the wire
		stripNext,  // advance repeat / bin
		stripLatch  // hold clkOut low
	} stripState;

endpackage

// ==== src/ws2801Shifter.sv ====
`timescale 1ns/10ps
// WS2801 serializer: sends one 24-bit colour MSB first on data and clock lines
module ws2801Shifter (
	input  logic                clk,
	input  logic                rst,
	input  logic                load,     // only while idle
	input  ledStripPkg::rgbWord word,
	output logic                dOut,
	output logic                clkOut,
	output logic                wordDone  // one cycle, after the last bit period
);
	import ledStripPkg::*;

	rgbWord                 shiftReg;  // msb is on the wire
	logic [bitCntWidth-1:0] bitCnt;    // bits already finished
	logic [phaseWidth-1:0]  phase;     // position inside one bit period
	logic                   busy;
	logic                   bitEnd;
	logic                   lastBit;

	assign bitEnd  = busy && (phase == phaseWidth'(freqDiv - 1));
	assign lastBit = bitCnt == bitCntWidth'(wordBits - 1);

	// ------------------------------------------------------------
	// wire side
	// ------------------------------------------------------------
	// first half of the period low, second half high
	assign clkOut = phase >= phaseWidth'(freqDiv / 2);
	assign dOut   = busy & shiftReg[wordBits-1]; // low when idle

	// ------------------------------------------------------------
	// bit and phase counters
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			phase    <= '0;
			bitCnt   <= '0;
			wordDone <= 1'b0;
		end else begin
			wordDone <= 1'b0;
			if (load && !busy) begin
				busy   <= 1'b1;
				phase  <= '0;
				bitCnt <= '0;
			end else if (busy) begin
				phase <= phase + 1'b1;               // wraps back to 0 at bit end
				if (bitEnd) begin
					if (lastBit) begin
						busy     <= 1'b0;
						wordDone <= 1'b1;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			end
		end
	end

	// shift register, data moves only at a bit boundary while clkOut goes low
	always_ff @(posedge clk) begin
		if (load && !busy) begin
			shiftReg <= word;
		end else if (bitEnd) begin
			shiftReg <= {shiftReg[wordBits-2:0], 1'b0};
		end
	end

endmodule

// ==== src/ledStripDriver.sv ====
`timescale 1ns/10ps
// strip driver: repeats each bin colour for its run, then holds the latch gap
module ledStripDriver (
	input  logic                                                        clk,
	input  logic                                                        rst,
	input  logic                                                        start,
	input  ledStripPkg::rgbWord [ledStripPkg::binQty-1:0]               rgb,
	input  logic [ledStripPkg::binQty-1:0][ledStripPkg::countWidth-1:0] ledCounts,
	output logic                                                        dOut,
	output logic                                                        clkOut,
	output logic                                                        done
);
	import ledStripPkg::*;

	stripState                      state;
	rgbWord [binQty-1:0]            rgbReg;   // frame captured on accept
	logic [binQty-1:0][countWidth-1:0] cntReg;
	logic [binIdxWidth-1:0]         binIdx;
	logic [countWidth-1:0]          repCnt;   // words already sent for this bin
	logic [latchWidth-1:0]          latchCnt;

	logic   load;
	logic   wordDone;
	logic   lastBin;
	logic   binEmpty;
	rgbWord word;

	assign lastBin  = binIdx == binIdxWidth'(binQty - 1);
	assign binEmpty = cntReg[binIdx] == '0;
	assign load     = (state == stripLoad) && !binEmpty; // shifter is idle here
	assign word     = rgbReg[binIdx];

	ws2801Shifter shifterInst (
		.clk      (clk     ),
		.rst      (rst     ),
		.load     (load    ),
		.word     (word    ),
		.dOut     (dOut    ),
		.clkOut   (clkOut  ),
		.wordDone (wordDone)
	);

	// ------------------------------------------------------------
	// frame walk
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= stripIdle;
			binIdx   <= '0;
			repCnt   <= '0;
			latchCnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				stripIdle: begin
					if (start) begin                 // frames while busy are dropped
						binIdx <= '0;
						repCnt <= '0;
						state  <= stripLoad;
					end
				end
				stripLoad: begin
					if (!binEmpty) begin
						state <= stripShift;
					end else if (lastBin) begin      // empty bin, skip in one cycle
						latchCnt <= '0;
						state    <= stripLatch;
					end else begin
						binIdx <= binIdx + 1'b1;
					end
				end
				stripShift: begin
					if (wordDone) begin
						state <= stripNext;
					end
				end
				stripNext: begin
					if (repCnt + 1'b1 == cntReg[binIdx]) begin
						repCnt <= '0;                // run finished
						if (lastBin) begin
							latchCnt <= '0;
							state    <= stripLatch;
						end else begin
							binIdx <= binIdx + 1'b1;
							state  <= stripLoad;
						end
					end else begin
						repCnt <= repCnt + 1'b1;     // same colour again
						state  <= stripLoad;
					end
				end
				stripLatch: begin
					// shifter idle, so clkOut stays low through the gap
					if (latchCnt == latchWidth'(latchCycles - 1)) begin
						done  <= 1'b1;
						state <= stripIdle;
					end else begin
						latchCnt <= latchCnt + 1'b1;
					end
				end
				default: state <= stripIdle;
			endcase
		end
	end

	// frame capture
	always_ff @(posedge clk) begin
		if (state == stripIdle && start) begin
			rgbReg <= rgb;
			cntReg <= ledCounts;
		end
	end

endmodule

// ==== src/linearVisualizer.sv ====
`timescale 1ns/10ps
// linear visualizer: per-bin LED run lengths and brightness-scaled colours from note bins
module linearVisualizer (
	input  logic                                                        clk,
	input  logic                                                        rst,
	input  logic                                                        start,
	input  noteFixedPkg::noteValue [ledStripPkg::binQty-1:0]            noteAmplitudes,
	input  noteFixedPkg::noteValue [ledStripPkg::binQty-1:0]            notePositions,
	output ledStripPkg::rgbWord [ledStripPkg::binQty-1:0]               rgb,
	output logic [ledStripPkg::binQty-1:0][ledStripPkg::countWidth-1:0] ledCounts,
	output logic                                                        frameValid
);
	import noteFixedPkg::*;
	import ledStripPkg::*;

	vizState                 state;
	logic [binIdxWidth-1:0]  binIdx;       // bin under computation

	noteValue [binQty-1:0]   ampReg;       // notes captured at start
	noteValue [binQty-1:0]   posReg;
	rgbWord [binQty-1:0]     workRgb;      // results built up bin by bin
	logic [binQty-1:0][countWidth-1:0] workCounts;

	logic [countWidth-1:0]   curWhole;     // whole part of this bin's position
	logic [countWidth-1:0]   nextWhole;    // whole part of the next one, or strip end
	logic [countWidth-1:0]   runLen;
	logic [7:0]              bright;
	logic [2:0]              mask;
	rgbWord                  binColour;

	// ------------------------------------------------------------
	// per-bin datapath
	// ------------------------------------------------------------
	always_comb begin
		curWhole = countWidth'(posReg[binIdx][noteWidth-1:fracBits]);
		if (binIdx == binIdxWidth'(binQty - 1)) begin
			nextWhole = countWidth'(ledCount);      // last bin runs to the strip end
		end else begin
			nextWhole = countWidth'(posReg[binIdx + 1'b1][noteWidth-1:fracBits]);
		end
		runLen = (nextWhole > curWhole) ? nextWhole - curWhole : '0; // clamp at zero

		// amplitude * 4, truncated to one byte
		bright = ampReg[binIdx][noteWidth-1:fracBits-2];
		mask   = paletteMask[binIdx];
		binColour = {mask[maskRed]   ? bright : 8'h00,
		             mask[maskGreen] ? bright : 8'h00,
		             mask[maskBlue]  ? bright : 8'h00};
	end

	// ------------------------------------------------------------
	// control FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= vizIdle;
			binIdx     <= '0;
			frameValid <= 1'b0;
		end else begin
			frameValid <= 1'b0;                     // single-cycle pulse
			case (state)
				vizIdle: begin
					if (start) begin
						binIdx <= '0;
						state  <= vizBin;
					end
				end
				vizBin: begin
					if (binIdx == binIdxWidth'(binQty - 1)) begin
						state <= vizPublish;
					end else begin
						binIdx <= binIdx + 1'b1;
					end
				end
				vizPublish: begin
					frameValid <= 1'b1;             // outputs update in this same edge
					state      <= vizIdle;
				end
				default: state <= vizIdle;
			endcase
		end
	end

	// payload: capture notes, fill work regs, publish the finished frame
	always_ff @(posedge clk) begin
		if (state == vizIdle && start) begin
			ampReg <= noteAmplitudes;
			posReg <= notePositions;
		end
		if (state == vizBin) begin
			workRgb[binIdx]    <= binColour;
			workCounts[binIdx] <= runLen;
		end
		if (state == vizPublish) begin
			rgb       <= workRgb;
			ledCounts <= workCounts;
		end
	end

endmodule

// ==== src/noteVisualizerTop.sv ====
`timescale 1ns/10ps
// note visualizer top: linear visualizer feeding the WS2801 strip driver
module noteVisualizerTop (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             start,
	input  noteFixedPkg::noteValue [ledStripPkg::binQty-1:0] noteAmplitudes,
	input  noteFixedPkg::noteValue [ledStripPkg::binQty-1:0] notePositions,
	output logic                                             dOut,
	output logic                                             clkOut,
	output logic                                             frameValid,
	output logic                                             driverDone
);
	import ledStripPkg::*;

	// ------------------------------------------------------------
	// visualizer to driver
	// ------------------------------------------------------------
	rgbWord [binQty-1:0]               rgb;       // held between frameValid pulses
	logic [binQty-1:0][countWidth-1:0] ledCounts;

	linearVisualizer lvInst (
		.clk            (clk           ),
		.rst            (rst           ),
		.start          (start         ),
		.noteAmplitudes (noteAmplitudes),
		.notePositions  (notePositions ),
		.rgb            (rgb           ),
		.ledCounts      (ledCounts     ),
		.frameValid     (frameValid    )  // also out to the port
	);

	ledStripDriver ldInst (
		.clk       (clk       ),
		.rst       (rst       ),
		.start     (frameValid),          // accepted only when driver idle
		.rgb       (rgb       ),
		.ledCounts (ledCounts ),
		.dOut      (dOut      ),
		.clkOut    (clkOut    ),
		.done      (driverDone)
	);

endmodule

// ==== verif/tbClockGen.sv ====
`timescale 1ns/10ps
// testbench clock and reset source, 8 ns clock with reset over the first three edges
module tbClockGen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;      // half of the 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;                // released on the third rising edge
	end

endmodule

// ==== verif/ws2801Monitor.sv ====
`timescale 1ns/10ps
// WS2801 line monitor: rebuilds colour words from dOut at each rise of clkOut
module ws2801Monitor (
	input  logic                clk,
	input  logic                rst,
	input  logic                dOut,
	input  logic                clkOut,
	output logic                wordValid,  // one cycle per received word
	output ledStripPkg::rgbWord rxWord
);
	import ledStripPkg::*;

	logic   clkOutPrev;             // clkOut at the previous system edge
	rgbWord shiftIn;                // msb arrives first, bits enter at the bottom
	int     bitCnt;

	// ------------------------------------------------------------
	// strip clock rise found against the last sample
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			clkOutPrev <= 1'b0;
			bitCnt     <= 0;
			wordValid  <= 1'b0;
		end else begin
			clkOutPrev <= clkOut;
			wordValid  <= 1'b0;
			if (clkOut && !clkOutPrev) begin
				shiftIn <= {shiftIn[wordBits-2:0], dOut};
				if (bitCnt == wordBits - 1) begin
					rxWord    <= {shiftIn[wordBits-2:0], dOut};  // 24th bit closes the word
					wordValid <= 1'b1;
					bitCnt    <= 0;
				end else begin
					bitCnt <= bitCnt + 1;
				end
			end
		end
	end

endmodule

// ==== verif/noteVisualizerTb.sv ====
`timescale 1ns/10ps
// note visualizer testbench with reference model, scoreboard, assertions and watchdog
module noteVisualizerTb;
	import noteFixedPkg::*;
	import ledStripPkg::*;

	localparam int randomFrames  = 20;
	localparam int plannedFrames = 3 + 3 + randomFrames;  // directed, held start, random
	localparam int frameCycles   = ledCount * wordBits * freqDiv + latchCycles + binQty + 20;

	logic                  clk;
	logic                  rst;
	logic                  start;
	logic                  started;      // first start has been driven
	noteValue [binQty-1:0] noteAmplitudes;
	noteValue [binQty-1:0] notePositions;
	logic                  dOut;
	logic                  clkOut;
	logic                  frameValid;
	logic                  driverDone;
	logic                  wordValid;
	rgbWord                rxWord;

	rgbWord                expQ[$];      // words still owed by the accepted frame
	noteValue [binQty-1:0] capAmp;       // notes taken at the visualizer's last start
	noteValue [binQty-1:0] capPos;
	int                    vizCnt;       // cycles until the modelled frameValid
	int                    lowCnt;       // clkOut low streak
	int                    cycleNo = 0;
	bit                    drvBusy;

	tbClockGen clockGen (.clk(clk), .rst(rst));

	noteVisualizerTop DUT (
		.clk            (clk           ),
		.rst            (rst           ),
		.start          (start         ),
		.noteAmplitudes (noteAmplitudes),
		.notePositions  (notePositions ),
		.dOut           (dOut          ),
		.clkOut         (clkOut        ),
		.frameValid     (frameValid    ),
		.driverDone     (driverDone    )
	);

	ws2801Monitor lineMon (
		.clk       (clk      ),
		.rst       (rst      ),
		.dOut      (dOut     ),
		.clkOut    (clkOut   ),
		.wordValid (wordValid),
		.rxWord    (rxWord   )
	);

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic int runLength(input noteValue [binQty-1:0] pos, input int b);
		int cur;
		int nxt;
		cur = int'(pos[b]) >> fracBits;                 // whole LED offset
		nxt = (b == binQty - 1) ? ledCount : int'(pos[b + 1]) >> fracBits;
		return (nxt > cur) ? nxt - cur : 0;
	endfunction

	function automatic rgbWord expectedColour(input noteValue amp, input int b);
		logic [2:0] hue;
		logic [7:0] level;
		case (b % 6)
			0: hue = 3'b100;        // red
			1: hue = 3'b110;        // yellow
			2: hue = 3'b010;        // green
			3: hue = 3'b011;        // cyan
			4: hue = 3'b001;        // blue
			default: hue = 3'b101;  // magenta
		endcase
		level = 8'((int'(amp) * 4) >> fracBits);        // amplitude times four
		return {hue[2] ? level : 8'h00, hue[1] ? level : 8'h00, hue[0] ? level : 8'h00};
	endfunction

	// ------------------------------------------------------------
	// scoreboard
	// ------------------------------------------------------------
	always @(posedge clk) begin
		bit fvExp;
		int b;
		int r;
		if (rst) begin
			vizCnt  = 0;
			lowCnt  = 0;
			drvBusy = 1'b0;
			expQ.delete();
		end else begin
			fvExp = 1'b0;
			if (vizCnt > 0) begin
				vizCnt = vizCnt - 1;
				fvExp  = vizCnt == 0;
			end
			assert (frameValid == fvExp) else reportFailure($sformatf(
				"Mismatch frameValid: expected %h, got %h", fvExp, frameValid));
			lowCnt = clkOut ? 0 : lowCnt + 1;
			if (wordValid) begin
				assert (expQ.size() > 0) else reportFailure("strip word with no frame pending");
				assert (rxWord == expQ[0]) else reportFailure($sformatf(
					"Mismatch rxWord: expected %h, got %h", expQ[0], rxWord));
				void'(expQ.pop_front());
			end
			if (driverDone) begin
				assert (drvBusy && expQ.size() == 0) else reportFailure($sformatf(
					"driverDone with no frame running or %0d words missing", expQ.size()));
				assert (lowCnt >= latchCycles) else reportFailure("latch gap too short");
				drvBusy = 1'b0;             // idle again in this very cycle
			end
			if (fvExp && !drvBusy) begin
				drvBusy = 1'b1;
				for (b = 0; b < binQty; b++) begin
					for (r = 0; r < runLength(capPos, b); r++) begin
						expQ.push_back(expectedColour(capAmp[b], b));
					end
				end
			end
			if (vizCnt == 0 && start) begin
				capAmp = noteAmplitudes;
				capPos = notePositions;
				vizCnt = binQty + 2;        // bins, publish, then seen one edge later
			end
		end
	end

	always @(posedge clk) cycleNo <= cycleNo + 1;

	assert property (@(posedge clk) (cycleNo > 0 && !started) |->
		!(dOut || clkOut || frameValid || driverDone))
		else reportFailure("an output was active before the first start");
	assert property (@(posedge clk) disable iff (rst) clkOut |-> $stable(dOut))
		else reportFailure("dOut changed while clkOut was high");
	assert property (@(posedge clk) disable iff (rst) driverDone |=> !driverDone)
		else reportFailure("driverDone was wider than one cycle");

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic waitDone();
		@(posedge clk);
		while (!driverDone) @(posedge clk);
	endtask

	task automatic playFrame();
		@(posedge clk);
		start   <= 1'b1;
		started <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		waitDone();
		repeat (4) @(posedge clk);
	endtask

	// positions from whole LED offsets and amplitudes graded by bin
	task automatic directedNotes(input int wholes[binQty]);
		noteValue [binQty-1:0] amps;
		noteValue [binQty-1:0] poss;
		int b;
		for (b = 0; b < binQty; b++) begin
			poss[b] = noteValue'((wholes[b] << fracBits) | (b * 60));
			amps[b] = noteValue'(((b * 5 + 3) << fracBits) | (b * 85));
		end
		@(posedge clk);
		noteAmplitudes <= amps;
		notePositions  <= poss;
	endtask

	task automatic randomNotes();
		noteValue [binQty-1:0] amps;
		noteValue [binQty-1:0] poss;
		int b;
		int whole;
		whole = $urandom_range(3, 0);
		for (b = 0; b < binQty; b++) begin
			poss[b] = noteValue'((whole << fracBits) | $urandom_range(1023, 0));
			amps[b] = noteValue'($urandom);
			whole   = whole + $urandom_range(5, 1);  // ascending and may pass the strip end
		end
		noteAmplitudes <= amps;
		notePositions  <= poss;
	endtask

	initial begin
		int holds;
		int n;
		void'($urandom(37));
		start          <= 1'b0;
		started        <= 1'b0;
		noteAmplitudes <= '0;
		notePositions  <= '0;
		@(posedge clk);
		while (rst) @(posedge clk);
		repeat (10) @(posedge clk);               // quiet idle after reset

		directedNotes('{0, 4, 8, 12, 16, 20, 24, 28, 32, 36, 40, 44});
		playFrame();
		// flat and falling steps with the last bin beyond the strip end and then on it
		directedNotes('{0, 3, 3, 2, 9, 9, 20, 14, 30, 41, 47, 55});
		playFrame();
		directedNotes('{5, 5, 12, 12, 12, 20, 33, 33, 40, 45, 48, 50});
		playFrame();

		// start held with fresh notes every cycle so frames drop while the driver is busy
		holds = 0;
		@(posedge clk);
		start <= 1'b1;
		while (holds < 2) begin
			@(posedge clk);
			randomNotes();
			if (driverDone) begin
				holds++;
			end
		end
		start <= 1'b0;
		waitDone();                               // frame taken just after the last done

		for (n = 0; n < randomFrames; n++) begin
			@(posedge clk);
			randomNotes();
			playFrame();
		end
		repeat (4) @(posedge clk);
		$display("** PASS **");
		$finish;
	end

	// watchdog sized from the frame budget
	initial begin
		repeat (2 * plannedFrames * frameCycles) @(posedge clk);
		reportFailure("timeout, the frames did not finish within the cycle budget");
	end

endmodule

// ==== verilog.f ====
src/noteFixedPkg.sv
src/ledStripPkg.sv
src/ws2801Shifter.sv
src/ledStripDriver.sv
src/linearVisualizer.sv
src/noteVisualizerTop.sv
verif/tbClockGen.sv
verif/ws2801Monitor.sv
verif/noteVisualizerTb.sv
